// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

  // controller FSM states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB,
    IRQ_TAKEN_ID,
    IRQ_TAKEN_IF
  } ctrl_state_t;

  // selects the next fetch address in the IF stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_t;

  // jump kind as reported by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_t;

  // strobes towards the exception controller
  typedef struct packed {
    logic exc_ack;
    logic irq_ack;
    // save the PC of the IF or the ID stage
    logic save_if;
    logic save_id;
    // mret restores the saved ID PC
    logic restore_id;
  } exc_ctrl_t;

endpackage

`default_nettype wire

// ==== fwd_pkg.sv ====
`default_nettype none

package fwd_pkg;

  // operand source mux selects in the ID stage
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_t;

  // one bit per source register of the ID instruction
  // set when a stage's destination equals that source
  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } operand_match_t;

  // matches of the EX, WB and ALU write ports
  typedef struct packed {
    operand_match_t ex;
    operand_match_t wb;
    operand_match_t alu;
  } stage_match_t;

  // selects for all three operands
  typedef struct packed {
    fwd_sel_t a;
    fwd_sel_t b;
    fwd_sel_t c;
  } fwd_sels_t;

endpackage

`default_nettype wire

// ==== ctrl_fsm.sv ====
`default_nettype none
`timescale 1ns/100ps

module ctrl_fsm
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  fetch_enable_i,
  input  wire logic                  instr_valid_i,
  input  wire logic                  branch_taken_ex_i,
  input  wire logic                  id_ready_i,
  input  wire logic                  ex_valid_i,
  input  wire logic                  ext_req_i,
  input  wire logic                  int_req_i,
  input  wire logic                  mret_insn_i,
  input  wire logic                  pipe_flush_i,
  input  wire logic                  jr_stall_i,
  input  wire ctrl_pkg::jump_kind_t  jump_in_dec_i,
  output logic                       busy_o,
  output logic                       first_fetch_o,
  output logic                       is_decoding_o,
  output logic                       instr_req_o,
  output logic                       pc_set_o,
  output logic                       halt_if_o,
  output logic                       halt_id_o,
  output ctrl_pkg::pc_mux_t          pc_mux_o,
  output ctrl_pkg::exc_ctrl_t        exc_o
);

  ctrl_pkg::ctrl_state_t state_q;
  ctrl_pkg::ctrl_state_t state_d;
  logic                  jump_done_q;
  logic                  jump_done_d;
  logic                  jump_in_dec;

  // only unconditional jumps are resolved in ID
  assign jump_in_dec = (jump_in_dec_i == ctrl_pkg::BRANCH_JAL) ||
                       (jump_in_dec_i == ctrl_pkg::BRANCH_JALR);

  ////////////////////
  // next state and strobes
  ////////////////////

  always_comb
  begin
    state_d       = state_q;
    jump_done_d   = jump_done_q;
    busy_o        = 1'b1;
    instr_req_o   = 1'b1;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = ctrl_pkg::PC_BOOT;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    exc_o         = '0;

    case (state_q)
      // idle after reset until the core is enabled
      ctrl_pkg::RESET:
      begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = ctrl_pkg::BOOT_SET;
      end

      // load the boot address into the fetch unit
      ctrl_pkg::BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_mux_o = ctrl_pkg::PC_BOOT;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      ctrl_pkg::WAIT_SLEEP:
      begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = ctrl_pkg::SLEEP;
      end

      // pipeline is empty, wake on enable or an external interrupt
      ctrl_pkg::SLEEP:
      begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || ext_req_i)
          state_d = ctrl_pkg::FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      ctrl_pkg::FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        if (id_ready_i)
          state_d = ctrl_pkg::DECODE;
        // interrupt is taken on the IF PC, nothing in ID yet
        if (ext_req_i)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = ctrl_pkg::IRQ_TAKEN_IF;
        end
      end

      ctrl_pkg::DECODE:
      begin
        // a taken branch in EX kills the ID instruction
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;
          if (ext_req_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
          else if (jump_in_dec)
          begin
            pc_mux_o = ctrl_pkg::PC_JUMP;
            // target known in ID, set once and only when jr operand is ready
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (mret_insn_i || int_req_i || pipe_flush_i)
          begin
            // mret, ecall/illegal and wfi all drain the pipe first
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
        end
        if (branch_taken_ex_i)
        begin
          pc_set_o = 1'b1;
          pc_mux_o = ctrl_pkg::PC_BRANCH;
        end
      end

      // hold IF and ID until EX has finished
      ctrl_pkg::FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = ext_req_i ? ctrl_pkg::IRQ_TAKEN_ID : ctrl_pkg::FLUSH_WB;
      end

      // EX and WB are empty, CSR state is now safe to update
      ctrl_pkg::FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (int_req_i)
        begin
          pc_set_o          = 1'b1;
          pc_mux_o          = ctrl_pkg::PC_EXCEPTION;
          exc_o.exc_ack     = 1'b1;
          exc_o.save_id     = 1'b1;
        end
        else if (mret_insn_i)
        begin
          pc_set_o          = 1'b1;
          pc_mux_o          = ctrl_pkg::PC_ERET;
          exc_o.restore_id  = 1'b1;
        end
        state_d = fetch_enable_i ? ctrl_pkg::DECODE : ctrl_pkg::WAIT_SLEEP;
      end

      ctrl_pkg::IRQ_TAKEN_ID:
      begin
        pc_set_o      = 1'b1;
        pc_mux_o      = ctrl_pkg::PC_EXCEPTION;
        exc_o.exc_ack = 1'b1;
        exc_o.irq_ack = 1'b1;
        exc_o.save_id = 1'b1;
        state_d       = ctrl_pkg::DECODE;
      end

      ctrl_pkg::IRQ_TAKEN_IF:
      begin
        pc_set_o      = 1'b1;
        pc_mux_o      = ctrl_pkg::PC_EXCEPTION;
        exc_o.exc_ack = 1'b1;
        exc_o.irq_ack = 1'b1;
        exc_o.save_if = 1'b1;
        state_d       = ctrl_pkg::DECODE;
      end

      // unused encodings fall back to reset
      default:
      begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // cleared once ID accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // no branch prediction in IF, so taken branches cannot follow each other
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("back-to-back taken branches");

  // a jump held in ID redirects fetch only once
  assert property (@(posedge clk) disable iff (!rst_n)
    (pc_set_o && (pc_mux_o == ctrl_pkg::PC_JUMP) && !id_ready_i)
      |=> !(pc_set_o && (pc_mux_o == ctrl_pkg::PC_JUMP)))
    else $error("jump set the pc twice");

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module hazard_unit
(
  input  wire logic                  is_decoding_i,
  input  wire logic                  illegal_insn_i,
  input  wire logic                  data_req_ex_i,
  input  wire logic                  regfile_we_ex_i,
  input  wire logic                  regfile_we_wb_i,
  input  wire logic                  regfile_alu_we_fw_i,
  input  wire ctrl_pkg::jump_kind_t  jump_in_dec_i,
  input  wire fwd_pkg::stage_match_t match_i,
  output logic                       load_stall_o,
  output logic                       jr_stall_o,
  output logic                       deassert_we_o
);

  always_comb
  begin
    // load in EX writes a register the ID instruction reads
    load_stall_o = data_req_ex_i && regfile_we_ex_i &&
                   (match_i.ex.a || match_i.ex.b || match_i.ex.c);

    // jalr target comes from operand a, wait until it sits in the regfile
    jr_stall_o = (jump_in_dec_i == ctrl_pkg::BRANCH_JALR) &&
                 ((regfile_we_wb_i && match_i.wb.a) ||
                  (regfile_we_ex_i && match_i.ex.a) ||
                  (regfile_alu_we_fw_i && match_i.alu.a));

    // stalled, killed or illegal instructions must not write back
    deassert_we_o = load_stall_o || jr_stall_o || !is_decoding_i || illegal_insn_i;
  end

endmodule

`default_nettype wire

// ==== fwd_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module fwd_unit
(
  input  wire logic                  regfile_we_wb_i,
  input  wire logic                  regfile_alu_we_fw_i,
  input  wire logic                  data_misaligned_i,
  input  wire logic                  mult_multicycle_i,
  input  wire fwd_pkg::stage_match_t match_i,
  output fwd_pkg::fwd_sels_t         fwd_sel_o
);

  always_comb
  begin
    // no hazard, read the register file
    fwd_sel_o.a = fwd_pkg::SEL_REGFILE;
    fwd_sel_o.b = fwd_pkg::SEL_REGFILE;
    fwd_sel_o.c = fwd_pkg::SEL_REGFILE;

    // older result from WB
    if (regfile_we_wb_i)
    begin
      if (match_i.wb.a)
        fwd_sel_o.a = fwd_pkg::SEL_FW_WB;
      if (match_i.wb.b)
        fwd_sel_o.b = fwd_pkg::SEL_FW_WB;
      if (match_i.wb.c)
        fwd_sel_o.c = fwd_pkg::SEL_FW_WB;
    end

    // younger ALU result wins over WB
    if (regfile_alu_we_fw_i)
    begin
      if (match_i.alu.a)
        fwd_sel_o.a = fwd_pkg::SEL_FW_EX;
      if (match_i.alu.b)
        fwd_sel_o.b = fwd_pkg::SEL_FW_EX;
      if (match_i.alu.c)
        fwd_sel_o.c = fwd_pkg::SEL_FW_EX;
    end

    // second half of a misaligned access reuses the address from EX
    if (data_misaligned_i)
    begin
      fwd_sel_o.a = fwd_pkg::SEL_FW_EX;
      fwd_sel_o.b = fwd_pkg::SEL_REGFILE;
    end
    // multicycle mul keeps its partial result on operand c
    else if (mult_multicycle_i)
    begin
      fwd_sel_o.c = fwd_pkg::SEL_FW_EX;
    end
  end

endmodule

`default_nettype wire

// ==== pipe_ctrl_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module pipe_ctrl_top
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // fetch and decode status
  input  wire logic                  fetch_enable_i,
  input  wire logic                  instr_valid_i,
  input  wire logic                  branch_taken_ex_i,
  input  wire logic                  id_ready_i,
  input  wire logic                  ex_valid_i,
  input  wire logic                  ext_req_i,
  input  wire logic                  int_req_i,
  input  wire logic                  mret_insn_i,
  input  wire logic                  pipe_flush_i,
  input  wire logic                  illegal_insn_i,
  input  wire ctrl_pkg::jump_kind_t  jump_in_dec_i,
  // register write ports and operand matches
  input  wire logic                  data_req_ex_i,
  input  wire logic                  regfile_we_ex_i,
  input  wire logic                  regfile_we_wb_i,
  input  wire logic                  regfile_alu_we_fw_i,
  input  wire logic                  data_misaligned_i,
  input  wire logic                  mult_multicycle_i,
  input  wire fwd_pkg::stage_match_t match_i,
  // controller outputs
  output logic                       busy_o,
  output logic                       first_fetch_o,
  output logic                       is_decoding_o,
  output logic                       instr_req_o,
  output logic                       pc_set_o,
  output logic                       halt_if_o,
  output logic                       halt_id_o,
  output ctrl_pkg::pc_mux_t          pc_mux_o,
  output ctrl_pkg::exc_ctrl_t        exc_o,
  // stalls and forwarding
  output logic                       load_stall_o,
  output logic                       jr_stall_o,
  output logic                       deassert_we_o,
  output fwd_pkg::fwd_sels_t         fwd_sel_o
);

  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .ext_req_i         (ext_req_i),
    .int_req_i         (int_req_i),
    .mret_insn_i       (mret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .jr_stall_i        (jr_stall_o),
    .jump_in_dec_i     (jump_in_dec_i),
    .busy_o            (busy_o),
    .first_fetch_o     (first_fetch_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .pc_mux_o          (pc_mux_o),
    .exc_o             (exc_o)
  );

  // jr_stall feeds the FSM, is_decoding comes back, no loop since
  // jr_stall does not depend on is_decoding
  hazard_unit u_hazard_unit (
    .is_decoding_i       (is_decoding_o),
    .illegal_insn_i      (illegal_insn_i),
    .data_req_ex_i       (data_req_ex_i),
    .regfile_we_ex_i     (regfile_we_ex_i),
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .jump_in_dec_i       (jump_in_dec_i),
    .match_i             (match_i),
    .load_stall_o        (load_stall_o),
    .jr_stall_o          (jr_stall_o),
    .deassert_we_o       (deassert_we_o)
  );

  fwd_unit u_fwd_unit (
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .data_misaligned_i   (data_misaligned_i),
    .mult_multicycle_i   (mult_multicycle_i),
    .match_i             (match_i),
    .fwd_sel_o           (fwd_sel_o)
  );

endmodule

`default_nettype wire

// ==== tb_pipe_ctrl_vectors.svh ====
`ifndef TB_PIPE_CTRL_VECTORS_SVH
`define TB_PIPE_CTRL_VECTORS_SVH

// stimulus: fe iv bt rdy ev ext int mret wfi ill jump(2) ld we_ex m_ex_a
// expected: pc_set mux(3) hif hid exc(ack irq sif sid rid) busy dec dwe ff req ls js

localparam int N_ROWS = 38;

// output patterns that come back often
localparam logic [17:0] EXP_IDLE     = 18'b0_000_0_0_00000_0_0_1_0_0_0_0;
localparam logic [17:0] EXP_FETCHING = 18'b0_000_0_0_00000_1_0_1_1_1_0_0;
localparam logic [17:0] EXP_DECODING = 18'b0_000_0_0_00000_1_1_0_0_1_0_0;
localparam logic [17:0] EXP_DRAINING = 18'b0_000_1_1_00000_1_1_0_0_1_0_0;
localparam logic [17:0] EXP_HALTED   = 18'b0_000_1_1_00000_1_0_1_0_1_0_0;
localparam logic [17:0] EXP_SLEEPING = 18'b0_000_1_1_00000_0_0_1_0_0_0_0;

vec_t vec_table [N_ROWS];

task automatic load_table;
  // idle after reset, boot, first fetch waits for id_ready
  vec_table[0]  = {15'b0_0_0_0_0_0_0_0_0_0_00_0_0_0, EXP_IDLE};
  vec_table[1]  = {15'b1_0_0_0_0_0_0_0_0_0_00_0_0_0, EXP_IDLE};
  vec_table[2]  = {15'b1_0_0_0_0_0_0_0_0_0_00_0_0_0, 18'b1_000_0_0_00000_1_0_1_0_1_0_0};
  vec_table[3]  = {15'b1_0_0_0_0_0_0_0_0_0_00_0_0_0, EXP_FETCHING};
  vec_table[4]  = {15'b1_0_0_0_0_0_0_0_0_0_00_0_0_0, EXP_FETCHING};
  vec_table[5]  = {15'b1_0_0_1_0_0_0_0_0_0_00_0_0_0, EXP_FETCHING};
  // jal sets the pc once while id is not ready
  vec_table[6]  = {15'b1_1_0_0_0_0_0_0_0_0_01_0_0_0, 18'b1_010_0_0_00000_1_1_0_0_1_0_0};
  vec_table[7]  = {15'b1_1_0_0_0_0_0_0_0_0_01_0_0_0, EXP_DECODING};
  vec_table[8]  = {15'b1_1_0_1_0_0_0_0_0_0_01_0_0_0, EXP_DECODING};
  vec_table[9]  = {15'b1_1_0_1_0_0_0_0_0_0_00_0_0_0, EXP_DECODING};
  // jalr waits for the ex write to clear
  vec_table[10] = {15'b1_1_0_0_0_0_0_0_0_0_10_0_1_1, 18'b0_000_0_0_00000_1_1_1_0_1_0_1};
  vec_table[11] = {15'b1_1_0_0_0_0_0_0_0_0_10_0_1_1, 18'b0_000_0_0_00000_1_1_1_0_1_0_1};
  vec_table[12] = {15'b1_1_0_0_0_0_0_0_0_0_10_0_0_0, 18'b1_010_0_0_00000_1_1_0_0_1_0_0};
  vec_table[13] = {15'b1_1_0_1_0_0_0_0_0_0_10_0_0_0, EXP_DECODING};
  // taken branch kills decode
  vec_table[14] = {15'b1_1_1_1_0_0_0_0_0_0_00_0_0_0, 18'b1_011_0_0_00000_1_0_1_0_1_0_0};
  vec_table[15] = {15'b1_1_0_1_0_0_0_0_0_0_00_0_0_0, EXP_DECODING};
  // load-use stall, then an illegal instruction
  vec_table[16] = {15'b1_1_0_0_0_0_0_0_0_0_00_1_1_1, 18'b0_000_0_0_00000_1_1_1_0_1_1_0};
  vec_table[17] = {15'b1_1_0_1_0_0_0_0_0_1_00_0_0_0, 18'b0_000_0_0_00000_1_1_1_0_1_0_0};
  // ecall drains ex and wb before the trap
  vec_table[18] = {15'b1_1_0_0_0_0_1_0_0_0_00_0_0_0, EXP_DRAINING};
  vec_table[19] = {15'b1_0_0_0_0_0_1_0_0_0_00_0_0_0, EXP_HALTED};
  vec_table[20] = {15'b1_0_0_0_0_0_1_0_0_0_00_0_0_0, EXP_HALTED};
  vec_table[21] = {15'b1_0_0_0_1_0_1_0_0_0_00_0_0_0, EXP_HALTED};
  vec_table[22] = {15'b1_0_0_0_0_0_1_0_0_0_00_0_0_0, 18'b1_100_1_1_10010_1_0_1_0_1_0_0};
  // mret
  vec_table[23] = {15'b1_1_0_0_0_0_0_1_0_0_00_0_0_0, EXP_DRAINING};
  vec_table[24] = {15'b1_0_0_0_1_0_0_1_0_0_00_0_0_0, EXP_HALTED};
  vec_table[25] = {15'b1_0_0_0_0_0_0_1_0_0_00_0_0_0, 18'b1_101_1_1_00001_1_0_1_0_1_0_0};
  // wfi with fetch disabled goes to sleep
  vec_table[26] = {15'b1_1_0_0_0_0_0_0_1_0_00_0_0_0, EXP_DRAINING};
  vec_table[27] = {15'b0_0_0_0_1_0_0_0_1_0_00_0_0_0, EXP_HALTED};
  vec_table[28] = {15'b0_0_0_0_0_0_0_0_0_0_00_0_0_0, EXP_HALTED};
  vec_table[29] = {15'b0_0_0_0_0_0_0_0_0_0_00_0_0_0, EXP_SLEEPING};
  vec_table[30] = {15'b0_0_0_0_0_0_0_0_0_0_00_0_0_0, EXP_SLEEPING};
  // external interrupt wakes the core and is taken from IF
  vec_table[31] = {15'b0_0_0_0_0_1_0_0_0_0_00_0_0_0, EXP_SLEEPING};
  vec_table[32] = {15'b1_0_0_0_0_1_0_0_0_0_00_0_0_0, 18'b0_000_1_1_00000_1_0_1_1_1_0_0};
  vec_table[33] = {15'b1_0_0_0_0_0_0_0_0_0_00_0_0_0, 18'b1_100_0_0_11100_1_0_1_0_1_0_0};
  // external interrupt taken from ID
  vec_table[34] = {15'b1_1_0_0_0_1_0_0_0_0_00_0_0_0, EXP_DRAINING};
  vec_table[35] = {15'b1_0_0_0_1_1_0_0_0_0_00_0_0_0, EXP_HALTED};
  vec_table[36] = {15'b1_0_0_0_0_0_0_0_0_0_00_0_0_0, 18'b1_100_0_0_11010_1_0_1_0_1_0_0};
  vec_table[37] = {15'b1_0_0_0_0_0_0_0_0_0_00_0_0_0, 18'b0_000_0_0_00000_1_0_1_0_1_0_0};
endtask

`endif

// ==== tb_pipe_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_pipe_ctrl;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;
  localparam int CHECK_DELAY  = 36;
  localparam int RESET_CYCLES = 16;
  localparam int N_RANDOM     = 200;

  // one table row, inputs first
  typedef struct packed {
    logic                 fetch_enable;
    logic                 instr_valid;
    logic                 branch_taken;
    logic                 id_ready;
    logic                 ex_valid;
    logic                 ext_req;
    logic                 int_req;
    logic                 mret;
    logic                 pipe_flush;
    logic                 illegal;
    ctrl_pkg::jump_kind_t jump;
    logic                 data_req;
    logic                 we_ex;
    logic                 match_ex_a;
  } stim_t;

  typedef struct packed {
    logic                pc_set;
    ctrl_pkg::pc_mux_t   pc_mux;
    logic                halt_if;
    logic                halt_id;
    ctrl_pkg::exc_ctrl_t exc;
    logic                busy;
    logic                is_decoding;
    logic                deassert_we;
    logic                first_fetch;
    logic                instr_req;
    logic                load_stall;
    logic                jr_stall;
  } expect_t;

  typedef struct packed {
    stim_t   stim;
    expect_t want;
  } vec_t;

  `include "tb_pipe_ctrl_vectors.svh"

  // reset, table and random phases plus some slack
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 1 + N_ROWS + N_RANDOM + 50;

  logic clk;
  logic rst_n;
  logic fetch_enable;
  logic instr_valid;
  logic branch_taken_ex;
  logic id_ready;
  logic ex_valid;
  logic ext_req;
  logic int_req;
  logic mret_insn;
  logic pipe_flush;
  logic illegal_insn;
  logic data_req_ex;
  logic regfile_we_ex;
  logic regfile_we_wb;
  logic regfile_alu_we_fw;
  logic data_misaligned;
  logic mult_multicycle;
  ctrl_pkg::jump_kind_t  jump_in_dec;
  fwd_pkg::stage_match_t match;

  logic busy;
  logic first_fetch;
  logic is_decoding;
  logic instr_req;
  logic pc_set;
  logic halt_if;
  logic halt_id;
  logic load_stall;
  logic jr_stall;
  logic deassert_we;
  ctrl_pkg::pc_mux_t   pc_mux;
  ctrl_pkg::exc_ctrl_t exc;
  fwd_pkg::fwd_sels_t  fwd_sel;

  int          errors;
  int          checks;
  int          cycle_count;
  logic [31:0] lfsr_q;

  pipe_ctrl_top DUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_enable_i      (fetch_enable),
    .instr_valid_i       (instr_valid),
    .branch_taken_ex_i   (branch_taken_ex),
    .id_ready_i          (id_ready),
    .ex_valid_i          (ex_valid),
    .ext_req_i           (ext_req),
    .int_req_i           (int_req),
    .mret_insn_i         (mret_insn),
    .pipe_flush_i        (pipe_flush),
    .illegal_insn_i      (illegal_insn),
    .jump_in_dec_i       (jump_in_dec),
    .data_req_ex_i       (data_req_ex),
    .regfile_we_ex_i     (regfile_we_ex),
    .regfile_we_wb_i     (regfile_we_wb),
    .regfile_alu_we_fw_i (regfile_alu_we_fw),
    .data_misaligned_i   (data_misaligned),
    .mult_multicycle_i   (mult_multicycle),
    .match_i             (match),
    .busy_o              (busy),
    .first_fetch_o       (first_fetch),
    .is_decoding_o       (is_decoding),
    .instr_req_o         (instr_req),
    .pc_set_o            (pc_set),
    .halt_if_o           (halt_if),
    .halt_id_o           (halt_id),
    .pc_mux_o            (pc_mux),
    .exc_o               (exc),
    .load_stall_o        (load_stall),
    .jr_stall_o          (jr_stall),
    .deassert_we_o       (deassert_we),
    .fwd_sel_o           (fwd_sel)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////

  // right shift Galois form, taps 32 30 26 25
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      lfsr_step = (s >> 1) ^ 32'hA300_0000;
    else
      lfsr_step = s >> 1;
  endfunction

  task automatic take_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
  endtask

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
    checks++;
    assert (got === want) else
    begin
      errors++;
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  // younger alu result beats wb, then the register file
  function automatic fwd_pkg::fwd_sel_t pick_source(input logic wb_hit, input logic alu_hit);
    if (alu_hit)
      pick_source = fwd_pkg::SEL_FW_EX;
    else if (wb_hit)
      pick_source = fwd_pkg::SEL_FW_WB;
    else
      pick_source = fwd_pkg::SEL_REGFILE;
  endfunction

  function automatic fwd_pkg::fwd_sels_t expected_fwd(input logic we_wb, input logic alu_we,
                                                      input logic misaligned, input logic mult,
                                                      input fwd_pkg::stage_match_t m);
    fwd_pkg::fwd_sels_t r;
    r.a = pick_source(we_wb && m.wb.a, alu_we && m.alu.a);
    r.b = pick_source(we_wb && m.wb.b, alu_we && m.alu.b);
    r.c = pick_source(we_wb && m.wb.c, alu_we && m.alu.c);
    // misaligned access has priority over the multicycle mul
    if (misaligned)
    begin
      r.a = fwd_pkg::SEL_FW_EX;
      r.b = fwd_pkg::SEL_REGFILE;
    end
    else if (mult)
      r.c = fwd_pkg::SEL_FW_EX;
    expected_fwd = r;
  endfunction

  task automatic apply_stim(input stim_t s);
    fetch_enable      = s.fetch_enable;
    instr_valid       = s.instr_valid;
    branch_taken_ex   = s.branch_taken;
    id_ready          = s.id_ready;
    ex_valid          = s.ex_valid;
    ext_req           = s.ext_req;
    int_req           = s.int_req;
    mret_insn         = s.mret;
    pipe_flush        = s.pipe_flush;
    illegal_insn      = s.illegal;
    jump_in_dec       = s.jump;
    data_req_ex       = s.data_req;
    regfile_we_ex     = s.we_ex;
    // only the ex match on operand a is used by the table
    match             = '0;
    match.ex.a        = s.match_ex_a;
    regfile_we_wb     = 1'b0;
    regfile_alu_we_fw = 1'b0;
    data_misaligned   = 1'b0;
    mult_multicycle   = 1'b0;
  endtask

  task automatic check_reset_idle;
    check_value("pc_set_o", 8'(pc_set), 8'h0);
    check_value("busy_o", 8'(busy), 8'h0);
    check_value("instr_req_o", 8'(instr_req), 8'h0);
    check_value("halt_if_o", 8'(halt_if), 8'h0);
    check_value("halt_id_o", 8'(halt_id), 8'h0);
    check_value("exc_o", 8'(exc), 8'h0);
    check_value("deassert_we_o", 8'(deassert_we), 8'h1);
  endtask

  task automatic check_row(input expect_t e);
    check_value("pc_set_o", 8'(pc_set), 8'(e.pc_set));
    // the mux select only matters while pc_set is high
    if (e.pc_set)
      check_value("pc_mux_o", 8'(pc_mux), 8'(e.pc_mux));
    check_value("halt_if_o", 8'(halt_if), 8'(e.halt_if));
    check_value("halt_id_o", 8'(halt_id), 8'(e.halt_id));
    check_value("exc_o", 8'(exc), 8'(e.exc));
    check_value("busy_o", 8'(busy), 8'(e.busy));
    check_value("is_decoding_o", 8'(is_decoding), 8'(e.is_decoding));
    check_value("deassert_we_o", 8'(deassert_we), 8'(e.deassert_we));
    check_value("first_fetch_o", 8'(first_fetch), 8'(e.first_fetch));
    check_value("instr_req_o", 8'(instr_req), 8'(e.instr_req));
    check_value("load_stall_o", 8'(load_stall), 8'(e.load_stall));
    check_value("jr_stall_o", 8'(jr_stall), 8'(e.jr_stall));
  endtask

  // fsm sits in decode, only hazard and forwarding inputs move
  task automatic run_random_fwd;
    logic [18:0]        bits;
    fwd_pkg::fwd_sels_t want;
    logic               want_ls;
    logic               want_js;
    int                 n;
    int                 k;
    for (n = 0; n < N_RANDOM; n++)
    begin
      for (k = 0; k < 19; k++)
        take_bit(bits[k]);
      @(posedge clk);
      #(DRIVE_DELAY);
      {instr_valid, illegal_insn, data_req_ex, regfile_we_ex, regfile_we_wb,
       regfile_alu_we_fw, data_misaligned, mult_multicycle} = bits[18:11];
      jump_in_dec = ctrl_pkg::jump_kind_t'(bits[10:9]);
      match       = bits[8:0];
      #(CHECK_DELAY);
      want    = expected_fwd(regfile_we_wb, regfile_alu_we_fw, data_misaligned,
                             mult_multicycle, match);
      // a load in EX that hits any source register
      want_ls = data_req_ex && regfile_we_ex && (match.ex != '0);
      // jalr waits while any writing stage hits operand a
      want_js = (jump_in_dec == ctrl_pkg::BRANCH_JALR) &&
                |{regfile_we_wb & match.wb.a, regfile_we_ex & match.ex.a,
                  regfile_alu_we_fw & match.alu.a};
      check_value("fwd_sel_o.a", 8'(fwd_sel.a), 8'(want.a));
      check_value("fwd_sel_o.b", 8'(fwd_sel.b), 8'(want.b));
      check_value("fwd_sel_o.c", 8'(fwd_sel.c), 8'(want.c));
      check_value("load_stall_o", 8'(load_stall), 8'(want_ls));
      check_value("jr_stall_o", 8'(jr_stall), 8'(want_js));
      check_value("is_decoding_o", 8'(is_decoding), 8'(instr_valid));
      check_value("deassert_we_o", 8'(deassert_we),
                  8'(want_ls || want_js || !instr_valid || illegal_insn));
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    errors = 0;
    checks = 0;
    lfsr_q = 32'h1da1_4152;
    rst_n  = 1'b0;
    apply_stim('0);
    load_table;

    repeat (RESET_CYCLES)
    begin
      @(posedge clk);
      #(DRIVE_DELAY + CHECK_DELAY);
      check_reset_idle;
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;

    // one row per cycle
    for (int i = 0; i < N_ROWS; i++)
    begin
      @(posedge clk);
      #(DRIVE_DELAY);
      apply_stim(vec_table[i].stim);
      #(CHECK_DELAY);
      check_row(vec_table[i].want);
    end

    run_random_fwd;

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // guard against a stuck run
  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the test did not finish", cycle_count);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
ctrl_pkg.sv
fwd_pkg.sv
ctrl_fsm.sv
hazard_unit.sv
fwd_unit.sv
pipe_ctrl_top.sv
tb_pipe_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module tb_pipe_ctrl
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/Vtb_pipe_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1
